// File: source/alloc_pkg.sv
// ----------------------------------------------------------
// Switch allocator shared definitions
// Port counts, index widths and flat vector types used by
// the separable allocator and its top level
// ----------------------------------------------------------
package alloc_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int NUM_INPUTS  = 4;  // Requesting input ports
  localparam int NUM_OUTPUTS = 4;  // Output resources

  localparam int IN_IDX_W  = 2;  // Bits to name an input
  localparam int OUT_IDX_W = 2;  // Bits to name an output

  // ----------------------------------------------------------
  // Row and column masks
  // ----------------------------------------------------------
  // One input's request row or grant row, bit j is output j
  typedef logic [NUM_OUTPUTS-1:0] out_mask_t;

  // One output's column of inputs, bit i is input i
  typedef logic [NUM_INPUTS-1:0] in_mask_t;

  // ----------------------------------------------------------
  // Flat matrices
  // ----------------------------------------------------------
  // Input i at bits i*NUM_OUTPUTS upward
  typedef logic [NUM_INPUTS*NUM_OUTPUTS-1:0] req_matrix_t;

  // Output j at bits j*NUM_INPUTS upward
  typedef logic [NUM_OUTPUTS*NUM_INPUTS-1:0] grant_matrix_t;

  // ----------------------------------------------------------
  // Indices
  // ----------------------------------------------------------
  typedef logic [IN_IDX_W-1:0]  in_idx_t;   // Input number
  typedef logic [OUT_IDX_W-1:0] out_idx_t;  // Output number

  // One input index per output, one output index per input
  typedef logic [NUM_OUTPUTS*IN_IDX_W-1:0] in_idx_vec_t;
  typedef logic [NUM_INPUTS*OUT_IDX_W-1:0] out_idx_vec_t;

endpackage

// File: source/rr_ppe.sv
// ----------------------------------------------------------
// Round-robin programmable priority encoder
// Grants the first request at or above a registered pointer
// and moves the pointer past the winner on enabled cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module rr_ppe #(
  parameter int WIDTH = 4  // Number of competing requesters
) (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_ce,       // Pointer update strobe
  input  logic [WIDTH-1:0] i_request,  // Request levels
  output logic [WIDTH-1:0] o_grant     // One-hot, or zero when idle
);

  // Pointer needs at least one bit even for a single requester
  localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  logic [PTR_W-1:0]   ptr_q;     // Highest priority position
  logic [PTR_W-1:0]   ptr_next;  // One past the winner
  logic [PTR_W-1:0]   win_pos;   // Position of the granted bit

  logic [2*WIDTH-1:0] req_dbl;   // Request repeated for rotation
  logic [2*WIDTH-1:0] req_shift;
  logic [WIDTH-1:0]   req_rot;   // Pointer position now at bit 0

  logic [WIDTH-1:0]   win_rot;   // Lowest set bit of rotated request
  logic [2*WIDTH-1:0] win_dbl;
  logic [2*WIDTH-1:0] win_shift;

  logic               any_req;

  // ----------------------------------------------------------
  // Rotate requests so the pointer lands on bit 0
  // ----------------------------------------------------------
  assign req_dbl   = {i_request, i_request};
  assign req_shift = req_dbl >> ptr_q;
  assign req_rot   = req_shift[WIDTH-1:0];  // bit k is request[(k+ptr) mod WIDTH]

  assign any_req = |i_request;

  // Isolate lowest set bit, two's complement trick
  assign win_rot = req_rot & (~req_rot + 1'b1);

  // ----------------------------------------------------------
  // Rotate the winner back to its real position
  // ----------------------------------------------------------
  assign win_dbl   = {win_rot, win_rot};
  assign win_shift = win_dbl << ptr_q;
  assign o_grant   = win_shift[2*WIDTH-1:WIDTH];  // Upper copy holds the wrapped result

  // Binary position of the one-hot grant
  always_comb begin
    win_pos = '0;
    for (int k = 0; k < WIDTH; k++) begin
      if (o_grant[k]) begin
        win_pos = PTR_W'(k);
      end
    end
  end

  // Next pointer, wraps at WIDTH even when not a power of two
  always_comb begin
    if (win_pos == PTR_W'(WIDTH - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = win_pos + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Priority pointer
  // ----------------------------------------------------------
  // Moves only on a real grant, so a losing requester keeps
  // its place and is served within WIDTH enabled grants
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ptr_q <= '0;
    end else if (i_ce && any_req) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

// File: source/sep_allocator.sv
// ----------------------------------------------------------
// Input-first separable allocator
// Input arbiters pick one output per input, the picks are
// transposed, then output arbiters pick one input per output
// ----------------------------------------------------------
`timescale 1ns/1ps

module sep_allocator
  import alloc_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_ce,       // Pointer update strobe for every arbiter
  input  req_matrix_t   i_request,  // Row per input, bit per output
  output grant_matrix_t o_grant     // Row per output, bit per input
);

  req_matrix_t   input_grant;   // Input stage result, row per input
  grant_matrix_t intermediate;  // Same bits, regrouped per output

  // ----------------------------------------------------------
  // Input stage
  // ----------------------------------------------------------
  // Each input chooses one of the outputs it asked for
  for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_input_arb
    rr_ppe #(
      .WIDTH (NUM_OUTPUTS)
    ) u_in_ppe (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_ce      (i_ce),
      .i_request (i_request[i*NUM_OUTPUTS +: NUM_OUTPUTS]),
      .o_grant   (input_grant[i*NUM_OUTPUTS +: NUM_OUTPUTS])
    );
  end

  // ----------------------------------------------------------
  // Transpose
  // ----------------------------------------------------------
  // Bit j of input row i becomes bit i of output column j
  always_comb begin
    intermediate = '0;
    for (int j = 0; j < NUM_OUTPUTS; j++) begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
        intermediate[j*NUM_INPUTS + i] = input_grant[i*NUM_OUTPUTS + j];
      end
    end
  end

  // ----------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------
  // Each output chooses one of the inputs that picked it.
  // An input offers itself to one output only, so the result
  // is a matching without any further checks
  for (genvar j = 0; j < NUM_OUTPUTS; j++) begin : g_output_arb
    rr_ppe #(
      .WIDTH (NUM_INPUTS)
    ) u_out_ppe (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_ce      (i_ce),
      .i_request (intermediate[j*NUM_INPUTS +: NUM_INPUTS]),
      .o_grant   (o_grant[j*NUM_INPUTS +: NUM_INPUTS])
    );
  end

  // Note the input arbiters advance even when their pick
  // loses at the output stage, as in the classic separable
  // scheme; fairness comes from the output pointers

endmodule

// File: source/switch_alloc_top.sv
// ----------------------------------------------------------
// Switch allocator top level
// Encodes the grant matrix into output selects and input
// grant flags, registered on the clock enable
// ----------------------------------------------------------
`timescale 1ns/1ps

module switch_alloc_top
  import alloc_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_ce,          // Allocation strobe
  input  req_matrix_t            i_request,     // Row per input, bit per output
  output logic [NUM_OUTPUTS-1:0] o_out_valid,   // Output j has a winner
  output in_idx_vec_t            o_out_sel,     // Winning input per output
  output logic [NUM_INPUTS-1:0]  o_in_granted,  // Input i won something
  output out_idx_vec_t           o_in_port      // Output won per input
);

  // ----------------------------------------------------------
  // One-hot to binary
  // ----------------------------------------------------------
  function automatic in_idx_t enc_in(input in_mask_t onehot);
    in_idx_t idx;
    idx = '0;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      if (onehot[i]) begin
        idx = IN_IDX_W'(i);
      end
    end
    return idx;
  endfunction

  function automatic out_idx_t enc_out(input out_mask_t onehot);
    out_idx_t idx;
    idx = '0;
    for (int j = 0; j < NUM_OUTPUTS; j++) begin
      if (onehot[j]) begin
        idx = OUT_IDX_W'(j);
      end
    end
    return idx;
  endfunction

  grant_matrix_t grant;  // Combinational allocation result

  in_mask_t  out_row [NUM_OUTPUTS];  // Inputs granted by output j
  out_mask_t in_row  [NUM_INPUTS];   // Outputs won by input i

  logic [NUM_OUTPUTS-1:0] out_valid_d;
  in_idx_vec_t            out_sel_d;
  logic [NUM_INPUTS-1:0]  in_granted_d;
  out_idx_vec_t           in_port_d;

  sep_allocator u_sep_allocator (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_ce      (i_ce),
    .i_request (i_request),
    .o_grant   (grant)
  );

  // ----------------------------------------------------------
  // Regroup the grant matrix both ways
  // ----------------------------------------------------------
  for (genvar j = 0; j < NUM_OUTPUTS; j++) begin : g_out_row
    assign out_row[j] = grant[j*NUM_INPUTS +: NUM_INPUTS];
  end

  for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_in_row
    for (genvar j = 0; j < NUM_OUTPUTS; j++) begin : g_bit
      assign in_row[i][j] = grant[j*NUM_INPUTS + i];  // Column bit of input i
    end
  end

  // ----------------------------------------------------------
  // Encode
  // ----------------------------------------------------------
  always_comb begin
    for (int j = 0; j < NUM_OUTPUTS; j++) begin
      out_valid_d[j]                       = |out_row[j];
      out_sel_d[j*IN_IDX_W +: IN_IDX_W]    = enc_in(out_row[j]);
    end
    for (int i = 0; i < NUM_INPUTS; i++) begin
      in_granted_d[i]                      = |in_row[i];    // At most one bit set
      in_port_d[i*OUT_IDX_W +: OUT_IDX_W]  = enc_out(in_row[i]);
    end
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------
  // Selects stay stable for a whole cycle for the crossbar
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_out_valid  <= '0;
      o_out_sel    <= '0;
      o_in_granted <= '0;
      o_in_port    <= '0;
    end else if (i_ce) begin
      o_out_valid  <= out_valid_d;
      o_out_sel    <= out_sel_d;
      o_in_granted <= in_granted_d;
      o_in_port    <= in_port_d;
    end
  end

endmodule

// File: dv/tb_switch_alloc.sv
// ----------------------------------------------------------
// Switch allocator testbench
// Directed and LCG-driven requests, a round-robin reference
// model and concurrent assertions on the registered grants
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_switch_alloc
  import alloc_pkg::*;
;

  // ----------------------------------------------------------
  // Run lengths
  // ----------------------------------------------------------
  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 16;
  localparam int IDLE_CYCLES   = 8;
  localparam int SINGLE_CYCLES = 2 * NUM_INPUTS * NUM_OUTPUTS;  // Two cycles per pair
  localparam int ROTATE_CYCLES = 8;                             // Two full turns
  localparam int RANDOM_CYCLES = 300;
  localparam int NUM_TESTS     = 6;
  localparam int MARGIN_CYCLES = 50;

  localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + IDLE_CYCLES + SINGLE_CYCLES +
                                ROTATE_CYCLES + 3 * RANDOM_CYCLES + 2 * NUM_TESTS;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  // All four outputs packed together
  localparam int OUTS_W = NUM_OUTPUTS + NUM_OUTPUTS * IN_IDX_W +
                          NUM_INPUTS + NUM_INPUTS * OUT_IDX_W;

  // ----------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------
  logic                   i_clk;
  logic                   i_reset;
  logic                   i_ce;
  req_matrix_t            i_request;
  logic [NUM_OUTPUTS-1:0] o_out_valid;
  in_idx_vec_t            o_out_sel;
  logic [NUM_INPUTS-1:0]  o_in_granted;
  out_idx_vec_t           o_in_port;

  logic [OUTS_W-1:0] cur_outs;
  assign cur_outs = {o_out_valid, o_out_sel, o_in_granted, o_in_port};

  // Reference model state
  int                     in_ptr  [NUM_INPUTS];   // Input stage pointers
  int                     out_ptr [NUM_OUTPUTS];  // Output stage pointers
  logic [NUM_OUTPUTS-1:0] exp_out_valid;
  in_idx_vec_t            exp_out_sel;
  logic [NUM_INPUTS-1:0]  exp_in_granted;
  out_idx_vec_t           exp_in_port;
  req_matrix_t            sampled_req;   // Matrix behind the registered grants
  logic [OUTS_W-1:0]      prev_outs;     // Outputs just before the last edge
  logic                   last_ce;
  logic                   last_rst;
  logic                   model_ready = 1'b0;

  // Directed check controls
  logic              idle_phase   = 1'b0;
  logic              single_phase = 1'b0;
  logic [OUTS_W-1:0] single_outs;
  logic              rot_phase    = 1'b0;
  in_idx_t           rot_expect;

  int          err_count  = 0;
  int          err_mark   = 0;  // Error count when the current test began
  int          pass_count = 0;
  int          fail_count = 0;
  int          test_num   = 0;
  int unsigned rng_state  = 18866;

  switch_alloc_top dut0 (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_ce         (i_ce),
    .i_request    (i_request),
    .o_out_valid  (o_out_valid),
    .o_out_sel    (o_out_sel),
    .o_in_granted (o_in_granted),
    .o_in_port    (o_in_port)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // Matching rules on the registered outputs
  function automatic bit matching_ok(input logic [NUM_OUTPUTS-1:0] valid,
                                     input in_idx_vec_t sel,
                                     input logic [NUM_INPUTS-1:0] granted,
                                     input out_idx_vec_t port,
                                     input req_matrix_t req);
    int i_won;
    int j_won;
    bit ok;
    ok = 1'b1;
    for (int j = 0; j < NUM_OUTPUTS; j++) begin
      if (valid[j]) begin
        i_won = int'(sel[j*IN_IDX_W +: IN_IDX_W]);
        if (!granted[i_won] || port[i_won*OUT_IDX_W +: OUT_IDX_W] != OUT_IDX_W'(j)) begin
          ok = 1'b0;
        end
        if (!req[i_won*NUM_OUTPUTS + j]) begin
          ok = 1'b0;  // Granted but never asked for
        end
        for (int k = j + 1; k < NUM_OUTPUTS; k++) begin
          if (valid[k] && sel[k*IN_IDX_W +: IN_IDX_W] == IN_IDX_W'(i_won)) begin
            ok = 1'b0;  // Same input under two outputs
          end
        end
      end
    end
    for (int i = 0; i < NUM_INPUTS; i++) begin
      if (granted[i]) begin
        j_won = int'(port[i*OUT_IDX_W +: OUT_IDX_W]);
        if (!valid[j_won] || sel[j_won*IN_IDX_W +: IN_IDX_W] != IN_IDX_W'(i)) begin
          ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic apply_inputs(input req_matrix_t req, input logic ce);
    i_request = req;
    i_ce      = ce;
  endtask

  // Waits for the last check of the test, then scores it
  task automatic finish_test(input string name);
    @(negedge i_clk);
    @(posedge i_clk);
    #1;  // Next test drives from here
    idle_phase   = 1'b0;
    single_phase = 1'b0;
    rot_phase    = 1'b0;
    test_num++;
    if (err_count == err_mark) begin
      pass_count++;
      $display("Test %0d %s: PASS", test_num, name);
    end else begin
      fail_count++;
      $display("Test %0d %s: FAIL with %0d errors", test_num, name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  task automatic hold_reset();
    i_reset = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    i_reset = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  // Reads inputs and DUT outputs before the edge updates them
  always @(posedge i_clk) begin : ref_model
    int in_choice [NUM_INPUTS];  // -1 when the input asks for nothing
    int win;
    int idx;
    model_ready = 1'b1;
    last_rst    = i_reset;
    last_ce     = i_ce;
    prev_outs   = cur_outs;
    if (i_reset) begin
      for (int i = 0; i < NUM_INPUTS; i++) in_ptr[i] = 0;
      for (int j = 0; j < NUM_OUTPUTS; j++) out_ptr[j] = 0;
      exp_out_valid  = '0;
      exp_out_sel    = '0;
      exp_in_granted = '0;
      exp_in_port    = '0;
      sampled_req    = '0;
    end else if (i_ce) begin
      // Each input takes its first request at or above its pointer
      for (int i = 0; i < NUM_INPUTS; i++) begin
        in_choice[i] = -1;
        for (int k = 0; k < NUM_OUTPUTS; k++) begin
          idx = (in_ptr[i] + k) % NUM_OUTPUTS;
          if (in_choice[i] < 0 && i_request[i*NUM_OUTPUTS + idx]) begin
            in_choice[i] = idx;
          end
        end
        if (in_choice[i] >= 0) in_ptr[i] = (in_choice[i] + 1) % NUM_OUTPUTS;
      end
      exp_out_valid  = '0;
      exp_out_sel    = '0;
      exp_in_granted = '0;
      exp_in_port    = '0;
      // Each output takes the first chooser at or above its pointer
      for (int j = 0; j < NUM_OUTPUTS; j++) begin
        win = -1;
        for (int k = 0; k < NUM_INPUTS; k++) begin
          idx = (out_ptr[j] + k) % NUM_INPUTS;
          if (win < 0 && in_choice[idx] == j) win = idx;
        end
        if (win >= 0) begin
          out_ptr[j]       = (win + 1) % NUM_INPUTS;
          exp_out_valid[j] = 1'b1;
          exp_out_sel[j*IN_IDX_W +: IN_IDX_W]    = IN_IDX_W'(win);
          exp_in_granted[win]                    = 1'b1;
          exp_in_port[win*OUT_IDX_W +: OUT_IDX_W] = OUT_IDX_W'(j);
        end
      end
      sampled_req = i_request;
    end
  end

  // ----------------------------------------------------------
  // Assertions, sampled mid-cycle
  // ----------------------------------------------------------
  a_out_valid: assert property (@(negedge i_clk) disable iff (!model_ready)
    o_out_valid == exp_out_valid)
    else begin
      $display("Mismatch o_out_valid expected %h actual %h", exp_out_valid, o_out_valid);
      err_count++;
    end

  a_out_sel: assert property (@(negedge i_clk) disable iff (!model_ready)
    o_out_sel == exp_out_sel)
    else begin
      $display("Mismatch o_out_sel expected %h actual %h", exp_out_sel, o_out_sel);
      err_count++;
    end

  a_in_granted: assert property (@(negedge i_clk) disable iff (!model_ready)
    o_in_granted == exp_in_granted)
    else begin
      $display("Mismatch o_in_granted expected %h actual %h", exp_in_granted, o_in_granted);
      err_count++;
    end

  a_in_port: assert property (@(negedge i_clk) disable iff (!model_ready)
    o_in_port == exp_in_port)
    else begin
      $display("Mismatch o_in_port expected %h actual %h", exp_in_port, o_in_port);
      err_count++;
    end

  a_matching: assert property (@(negedge i_clk) disable iff (!model_ready)
    matching_ok(o_out_valid, o_out_sel, o_in_granted, o_in_port, sampled_req))
    else begin
      $display("Grant outputs are not a matching of the sampled request matrix %h",
               sampled_req);
      err_count++;
    end

  a_idle: assert property (@(negedge i_clk) disable iff (!model_ready)
    idle_phase |-> (o_out_valid == '0 && o_in_granted == '0))
    else begin
      $display("Mismatch o_out_valid/o_in_granted expected 0 actual %h/%h",
               o_out_valid, o_in_granted);
      err_count++;
    end

  a_single: assert property (@(negedge i_clk) disable iff (!model_ready)
    single_phase |-> (cur_outs == single_outs))
    else begin
      $display("Mismatch {o_out_valid,o_out_sel,o_in_granted,o_in_port} expected %h actual %h",
               single_outs, cur_outs);
      err_count++;
    end

  a_rotate: assert property (@(negedge i_clk) disable iff (!model_ready)
    rot_phase |-> (o_out_valid[0] && o_out_sel[IN_IDX_W-1:0] == rot_expect))
    else begin
      $display("Mismatch o_out_sel[0] expected %h actual %h", rot_expect,
               o_out_sel[IN_IDX_W-1:0]);
      err_count++;
    end

  // Disabled edge must leave every output untouched
  a_hold: assert property (@(negedge i_clk) disable iff (!model_ready)
    (!last_rst && !last_ce) |-> (cur_outs == prev_outs))
    else begin
      $display("Mismatch {o_out_valid,o_out_sel,o_in_granted,o_in_port} expected %h actual %h",
               prev_outs, cur_outs);
      err_count++;
    end

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin : main
    logic [31:0]            r1;
    logic [31:0]            r2;
    logic [NUM_OUTPUTS-1:0] valid;
    in_idx_vec_t            sel;
    logic [NUM_INPUTS-1:0]  granted;
    out_idx_vec_t           port;
    req_matrix_t            req;

    i_reset   = 1'b1;
    i_ce      = 1'b0;
    i_request = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_reset = 1'b0;

    // Quiet after reset
    idle_phase = 1'b1;
    apply_inputs('0, 1'b1);
    repeat (IDLE_CYCLES) next_cycle();
    finish_test("reset idle");

    // One request at a time, every input and output pair
    for (int i = 0; i < NUM_INPUTS; i++) begin
      for (int j = 0; j < NUM_OUTPUTS; j++) begin
        req = '0;
        req[i*NUM_OUTPUTS + j] = 1'b1;
        apply_inputs(req, 1'b1);
        next_cycle();
        valid   = '0;
        sel     = '0;
        granted = '0;
        port    = '0;
        valid[j]   = 1'b1;
        granted[i] = 1'b1;
        sel[j*IN_IDX_W +: IN_IDX_W]   = IN_IDX_W'(i);
        port[i*OUT_IDX_W +: OUT_IDX_W] = OUT_IDX_W'(j);
        single_outs  = {valid, sel, granted, port};
        single_phase = 1'b1;
        apply_inputs('0, 1'b1);
        @(negedge i_clk);
        #1;
        single_phase = 1'b0;
        next_cycle();
      end
    end
    finish_test("single request");

    // Everyone wants output 0, starting from fresh pointers
    apply_inputs('0, 1'b0);
    hold_reset();
    apply_inputs(req_matrix_t'(16'h1111), 1'b1);
    next_cycle();
    rot_expect = '0;
    rot_phase  = 1'b1;
    for (int n = 1; n < ROTATE_CYCLES; n++) begin
      next_cycle();
      rot_expect = rot_expect + 1'b1;
    end
    finish_test("output rotation");

    // Dense requests, lots of contention
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      r1 = lcg_next();
      r2 = lcg_next();
      apply_inputs(r1[30:15] | r2[30:15], 1'b1);
      next_cycle();
    end
    finish_test("random matching");

    // Mix of sparse and plain random matrices
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      r1 = lcg_next();
      r2 = lcg_next();
      if (r2[3]) begin
        apply_inputs(r1[30:15] & r2[30:15], 1'b1);
      end else begin
        apply_inputs(r1[30:15], 1'b1);
      end
      next_cycle();
    end
    finish_test("random model");

    // Enable dropped about a quarter of the time
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      r1 = lcg_next();
      r2 = lcg_next();
      apply_inputs(r1[30:15], r2[20] | r2[21]);
      next_cycle();
    end
    finish_test("enable hold");

    $display("Tests passed %0d failed %0d, assertion errors %0d",
             pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: switch_alloc_top.f
source/alloc_pkg.sv
source/rr_ppe.sv
source/sep_allocator.sv
source/switch_alloc_top.sv
dv/tb_switch_alloc.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the switch allocator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f switch_alloc_top.f \
  --top-module tb_switch_alloc \
  -o sim_tb_switch_alloc

out=$(./obj_dir/sim_tb_switch_alloc)
echo "$out"

# Pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Simulation completed successfully"; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi
